// File: Bender.yml
package:
  name: cdc_fifo

sources:
  - src/cdc_fifo_pkg.sv
  - src/wr_ptr_full.sv
  - src/rd_ptr_empty.sv
  - src/ptr_sync.sv
  - src/fifo_mem.sv
  - src/cdc_fifo.sv
  - target: simulation
    files:
      - sim/tb_cdc_fifo.sv

// File: cdc_fifo.f
src/cdc_fifo_pkg.sv
src/wr_ptr_full.sv
src/rd_ptr_empty.sv
src/ptr_sync.sv
src/fifo_mem.sv
src/cdc_fifo.sv
sim/tb_cdc_fifo.sv

// File: sim/cdc_fifo_input.txt
# op (IDLE PUSH POP BOTH), count in cycles, data as hex start value, rand or -
# every IDLE of 8 or more cycles ends with a check of the settled flags and counts
IDLE  10  -      # empty FIFO after reset
PUSH  4   0100
IDLE  10  -
POP   4   -
IDLE  10  -
PUSH  20  1000   # four words dropped on overflow
IDLE  10  -      # full with 16 words
POP   16  -
IDLE  10  -
POP   5   -      # pops while empty
IDLE  10  -
PUSH  1   2000
IDLE  10  -
POP   1   -
IDLE  10  -
PUSH  15  3000   # almost full boundary
IDLE  10  -
POP   14  -      # one word left
IDLE  10  -
POP   1   -
IDLE  10  -
PUSH  6   rand
IDLE  10  -
POP   6   -
BOTH  200 rand   # random traffic on both clocks
IDLE  10  -
BOTH  200 rand
IDLE  10  -
POP   20  -      # drain
IDLE  10  -

// File: sim/tb_cdc_fifo.sv
// ####################
// dual-clock FIFO testbench: clocks, resets,
// phase file reader, queue model, checks, timeout
// ####################
`timescale 1ns/10ps

module tb_cdc_fifo
    import cdc_fifo_pkg::*;
();

    typedef enum int {OP_IDLE, OP_PUSH, OP_POP, OP_BOTH} op_e;

    logic       wr_clk_i;
    logic       wr_rst_i;
    logic       push_i;
    data_t      wr_data_i;
    logic       rd_clk_i;
    logic       rd_rst_i;
    logic       pop_i;
    data_t      rd_data_o;
    wr_status_t wr_status_o;
    rd_status_t rd_status_o;

    data_t model_q[$];  // words accepted but not yet popped
    data_t rd_model;    // value rd_data_o should hold
    int    op_q[$];
    int    cnt_q[$];
    data_t val_q[$];
    bit    rnd_q[$];
    int    cycle_cnt;
    int    cycle_limit;

    cdc_fifo dut_i (
        .wr_clk_i   (wr_clk_i),
        .wr_rst_i   (wr_rst_i),
        .push_i     (push_i),
        .wr_data_i  (wr_data_i),
        .rd_clk_i   (rd_clk_i),
        .rd_rst_i   (rd_rst_i),
        .pop_i      (pop_i),
        .rd_data_o  (rd_data_o),
        .wr_status_o(wr_status_o),
        .rd_status_o(rd_status_o)
    );

    always #20 rd_clk_i = ~rd_clk_i;
    always #14 wr_clk_i = ~wr_clk_i;  // unrelated to the read clock

    task automatic stop_with_fail(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_fail($sformatf("FAIL at %0d ns: %s is %0h, expected %0h",
                                     $time, name, got, exp));
        end
    endtask

    // full is registered, so its value now decides the next write edge
    always @(negedge wr_clk_i) begin
        if (!wr_rst_i && push_i && !wr_status_o.full) begin
            if (model_q.size() >= FIFO_DEPTH) begin
                stop_with_fail("write side accepted a word while the FIFO was full");
            end else begin
                model_q.push_back(wr_data_i);
            end
        end
    end

    always @(negedge rd_clk_i) begin
        if (!rd_rst_i) begin
            check_value("rd_data_o", rd_data_o, rd_model);
            if (pop_i && !rd_status_o.empty) begin
                if (model_q.size() == 0) begin
                    stop_with_fail("read side popped a word that was never written");
                end else begin
                    rd_model = model_q.pop_front();  // due after next edge
                end
            end
        end
    end

    always @(posedge rd_clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            stop_with_fail($sformatf("timeout: run hung after %0d read clock cycles",
                                     cycle_cnt));
        end
    end

    task automatic read_phases();
        int               fd;
        int               n;
        int               cnt;
        logic [8*128-1:0] line;
        logic [8*8-1:0]   op;
        logic [8*8-1:0]   dstr;
        data_t            val;
        fd = $fopen("sim/cdc_fifo_input.txt", "r");
        if (fd == 0) begin
            stop_with_fail("cannot open sim/cdc_fifo_input.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%s %d %s", op, cnt, dstr);
                if (n == 3) begin  // comment and blank lines give fewer fields
                    val = '0;
                    if (dstr != "rand" && dstr != "-") begin
                        n = $sscanf(dstr, "%h", val);
                    end
                    case (op)
                        "IDLE":  op_q.push_back(OP_IDLE);
                        "PUSH":  op_q.push_back(OP_PUSH);
                        "POP":   op_q.push_back(OP_POP);
                        "BOTH":  op_q.push_back(OP_BOTH);
                        default: begin
                            stop_with_fail($sformatf("unknown operation %0s in input file",
                                                     op));
                        end
                    endcase
                    cnt_q.push_back(cnt);
                    val_q.push_back(val);
                    rnd_q.push_back(dstr == "rand");
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_push(input int cnt, input data_t start, input bit rnd);
        data_t d;
        d = start;
        for (int i = 0; i < cnt; i++) begin
            @(posedge wr_clk_i);
            push_i    <= 1'b1;
            wr_data_i <= rnd ? data_t'($urandom) : d;
            d = d + 1'b1;
        end
        @(posedge wr_clk_i);
        push_i <= 1'b0;
    endtask

    task automatic run_pop(input int cnt);
        for (int i = 0; i < cnt; i++) begin
            @(posedge rd_clk_i);
            pop_i <= 1'b1;
        end
        @(posedge rd_clk_i);
        pop_i <= 1'b0;
    endtask

    task automatic run_both(input int cnt);
        fork
            begin
                for (int i = 0; i < cnt; i++) begin
                    @(posedge wr_clk_i);
                    push_i    <= ($urandom % 2) == 0;
                    wr_data_i <= data_t'($urandom);
                end
                @(posedge wr_clk_i);
                push_i <= 1'b0;
            end
            begin
                for (int i = 0; i < cnt; i++) begin
                    @(posedge rd_clk_i);
                    pop_i <= ($urandom % 4) != 0;  // reads a bit faster on average
                end
                @(posedge rd_clk_i);
                pop_i <= 1'b0;
            end
        join
    endtask

    // both pointers have crossed, so flags and counts match the model
    task automatic check_settled();
        int n;
        @(negedge rd_clk_i);
        n = model_q.size();
        check_value("wr_cnt", wr_status_o.wr_cnt, n);
        check_value("rd_cnt", rd_status_o.rd_cnt, n);
        check_value("full", wr_status_o.full, n == FIFO_DEPTH);
        check_value("a_full", wr_status_o.a_full, n >= FIFO_DEPTH - 1);
        check_value("empty", rd_status_o.empty, n == 0);
        check_value("a_empty", rd_status_o.a_empty, n <= 1);
    endtask

    initial begin
        int unsigned seed;
        int          total;
        rd_clk_i    = 1'b0;
        wr_clk_i    = 1'b0;
        rd_rst_i    = 1'b1;
        wr_rst_i    = 1'b1;
        push_i      = 1'b0;
        pop_i       = 1'b0;
        wr_data_i   = '0;
        rd_model    = '0;
        cycle_cnt   = 0;
        cycle_limit = 0;
        seed        = $urandom(72870);
        read_phases();
        total = 0;
        foreach (cnt_q[i]) begin
            total += cnt_q[i];
        end
        cycle_limit = total * 4 + 200;
        fork
            begin
                repeat (4) @(posedge wr_clk_i);
                wr_rst_i <= 1'b0;
            end
            begin
                repeat (4) @(posedge rd_clk_i);
                rd_rst_i <= 1'b0;
            end
        join
        @(negedge rd_clk_i);
        check_value("full", wr_status_o.full, 0);
        check_value("a_full", wr_status_o.a_full, 0);
        check_value("wr_cnt", wr_status_o.wr_cnt, 0);
        check_value("empty", rd_status_o.empty, 1);
        check_value("a_empty", rd_status_o.a_empty, 1);
        check_value("rd_cnt", rd_status_o.rd_cnt, 0);
        check_value("rd_data_o", rd_data_o, 0);
        for (int p = 0; p < op_q.size(); p++) begin
            case (op_q[p])
                OP_PUSH: run_push(cnt_q[p], val_q[p], rnd_q[p]);
                OP_POP:  run_pop(cnt_q[p]);
                OP_BOTH: run_both(cnt_q[p]);
                default: begin
                    repeat (cnt_q[p]) @(posedge rd_clk_i);
                    if (cnt_q[p] >= 8) begin
                        check_settled();
                    end
                end
            endcase
        end
        @(negedge rd_clk_i);
        if (model_q.size() == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            stop_with_fail($sformatf("%0d words never came out of the FIFO",
                                     model_q.size()));
        end
    end

endmodule

// File: src/cdc_fifo.sv
// ####################
// dual-clock FIFO top: write side, read side,
// two pointer synchronizers, storage
// ####################
`timescale 1ns/10ps

module cdc_fifo
    import cdc_fifo_pkg::*;
(
    // write domain
    input  logic       wr_clk_i,
    input  logic       wr_rst_i,
    input  logic       push_i,
    input  data_t      wr_data_i,
    // read domain
    input  logic       rd_clk_i,
    input  logic       rd_rst_i,
    input  logic       pop_i,
    output data_t      rd_data_o,
    // status
    output wr_status_t wr_status_o,
    output rd_status_t rd_status_o
);

    ptr_t  wr_ptr;
    ptr_t  rd_ptr;
    ptr_t  wr_ptr_rsync;  // write pointer seen by the read side
    ptr_t  rd_ptr_wsync;  // read pointer seen by the write side
    addr_t wr_addr;
    addr_t rd_addr;
    logic  wr_en;
    logic  rd_en;

    wr_ptr_full i_wr_ptr_full (
        .wr_clk_i   (wr_clk_i),
        .wr_rst_i   (wr_rst_i),
        .push_i     (push_i),
        .rq_ptr_i   (rd_ptr_wsync),
        .wr_en_o    (wr_en),
        .wr_addr_o  (wr_addr),
        .wr_ptr_o   (wr_ptr),
        .wr_status_o(wr_status_o)
    );

    ptr_sync i_wr_ptr_sync (
        .clk_i(rd_clk_i),
        .rst_i(rd_rst_i),
        .ptr_i(wr_ptr),
        .ptr_o(wr_ptr_rsync)
    );

    ptr_sync i_rd_ptr_sync (
        .clk_i(wr_clk_i),
        .rst_i(wr_rst_i),
        .ptr_i(rd_ptr),
        .ptr_o(rd_ptr_wsync)
    );

    fifo_mem i_fifo_mem (
        .wr_clk_i (wr_clk_i),
        .wr_en_i  (wr_en),
        .wr_addr_i(wr_addr),
        .wr_data_i(wr_data_i),
        .rd_clk_i (rd_clk_i),
        .rd_rst_i (rd_rst_i),
        .rd_en_i  (rd_en),
        .rd_addr_i(rd_addr),
        .rd_data_o(rd_data_o)
    );

    rd_ptr_empty i_rd_ptr_empty (
        .rd_clk_i   (rd_clk_i),
        .rd_rst_i   (rd_rst_i),
        .pop_i      (pop_i),
        .wq_ptr_i   (wr_ptr_rsync),
        .rd_en_o    (rd_en),
        .rd_addr_o  (rd_addr),
        .rd_ptr_o   (rd_ptr),
        .rd_status_o(rd_status_o)
    );

endmodule

// File: src/cdc_fifo_pkg.sv
// ####################
// dual-clock FIFO sizes, word and pointer types,
// status structs, gray decode
// ####################
package cdc_fifo_pkg;

    localparam int FIFO_WIDTH  = 16;
    localparam int FIFO_DEPTH  = 16;
    localparam int ADDR_WIDTH  = 4;  // log2 of depth
    localparam int CDC_REG_NUM = 2;  // at least 2

    typedef logic [FIFO_WIDTH-1:0] data_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [ADDR_WIDTH:0]   ptr_t;   // extra wrap bit
    typedef logic [ADDR_WIDTH:0]   cnt_t;   // 0 .. depth

    typedef struct packed {
        logic full;
        logic a_full;
        cnt_t wr_cnt;
    } wr_status_t;

    typedef struct packed {
        logic empty;
        logic a_empty;
        cnt_t rd_cnt;
    } rd_status_t;

    function automatic ptr_t gray_to_bin(input ptr_t gray);
        ptr_t bin;
        bin[ADDR_WIDTH] = gray[ADDR_WIDTH];
        for (int i = ADDR_WIDTH - 1; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage

// File: src/fifo_mem.sv
// ####################
// simple dual-port storage, read-first,
// registered read port
// ####################
`timescale 1ns/10ps

module fifo_mem
    import cdc_fifo_pkg::*;
(
    input  logic  wr_clk_i,
    input  logic  wr_en_i,
    input  addr_t wr_addr_i,
    input  data_t wr_data_i,
    input  logic  rd_clk_i,
    input  logic  rd_rst_i,
    input  logic  rd_en_i,
    input  addr_t rd_addr_i,
    output data_t rd_data_o
);

    data_t mem [FIFO_DEPTH];

    always_ff @(posedge wr_clk_i) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // old word comes out on an address collision
    always_ff @(posedge rd_clk_i) begin
        if (rd_rst_i) begin
            rd_data_o <= '0;
        end else if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

// File: src/ptr_sync.sv
// ####################
// flop chain synchronizer for a gray pointer
// ####################
`timescale 1ns/10ps

module ptr_sync
    import cdc_fifo_pkg::*;
(
    input  logic clk_i,
    input  logic rst_i,
    input  ptr_t ptr_i,
    output ptr_t ptr_o
);

    if (CDC_REG_NUM < 2) begin : g_len_err
        $error("ptr_sync needs CDC_REG_NUM of at least 2");
    end

    ptr_t sync_q [CDC_REG_NUM];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sync_q <= '{default: '0};
        end else begin
            sync_q[0] <= ptr_i;  // first stage may go metastable
            for (int i = 1; i < CDC_REG_NUM; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign ptr_o = sync_q[CDC_REG_NUM-1];

endmodule

// File: src/rd_ptr_empty.sv
// ####################
// read side: pointer, empty and almost-empty flags, fill count
// ####################
`timescale 1ns/10ps

module rd_ptr_empty
    import cdc_fifo_pkg::*;
(
    input  logic       rd_clk_i,
    input  logic       rd_rst_i,
    input  logic       pop_i,
    input  ptr_t       wq_ptr_i,     // write gray pointer, already synchronized
    output logic       rd_en_o,
    output addr_t      rd_addr_o,
    output ptr_t       rd_ptr_o,
    output rd_status_t rd_status_o
);

    ptr_t       rd_bin;
    ptr_t       rd_gray;
    ptr_t       rd_bin_next;
    ptr_t       rd_gray_next;
    ptr_t       wq_bin;
    cnt_t       cnt_next;
    rd_status_t status_q;

    assign rd_en_o      = pop_i & ~status_q.empty;
    assign rd_bin_next  = rd_bin + ptr_t'(rd_en_o);
    assign rd_gray_next = (rd_bin_next >> 1) ^ rd_bin_next;
    assign wq_bin       = gray_to_bin(wq_ptr_i);
    assign cnt_next     = wq_bin - rd_bin_next;

    always_ff @(posedge rd_clk_i) begin
        if (rd_rst_i) begin
            rd_bin           <= '0;
            rd_gray          <= '0;
            status_q.empty   <= 1'b1;
            status_q.a_empty <= 1'b1;
            status_q.rd_cnt  <= '0;
        end else begin
            rd_bin           <= rd_bin_next;
            rd_gray          <= rd_gray_next;
            status_q.empty   <= (rd_gray_next == wq_ptr_i);
            status_q.a_empty <= (cnt_next <= cnt_t'(1));
            status_q.rd_cnt  <= wq_bin - rd_bin;  // lags pointer by one edge
        end
    end

    assign rd_addr_o   = rd_bin[ADDR_WIDTH-1:0];
    assign rd_ptr_o    = rd_gray;
    assign rd_status_o = status_q;

    // read pointer must not move past the write pointer
    a_no_adv_empty: assert property (@(posedge rd_clk_i) disable iff (rd_rst_i)
        (rd_bin == wq_bin) |=> $stable(rd_gray));

endmodule

// File: src/wr_ptr_full.sv
// ####################
// write side: pointer, full and almost-full flags, fill count
// ####################
`timescale 1ns/10ps

module wr_ptr_full
    import cdc_fifo_pkg::*;
(
    input  logic       wr_clk_i,
    input  logic       wr_rst_i,
    input  logic       push_i,
    input  ptr_t       rq_ptr_i,     // read gray pointer, already synchronized
    output logic       wr_en_o,
    output addr_t      wr_addr_o,
    output ptr_t       wr_ptr_o,
    output wr_status_t wr_status_o
);

    ptr_t       wr_bin;
    ptr_t       wr_gray;
    ptr_t       wr_bin_next;
    ptr_t       wr_gray_next;
    ptr_t       rq_bin;
    cnt_t       cnt_next;
    wr_status_t status_q;

    assign wr_en_o      = push_i & ~status_q.full;
    assign wr_bin_next  = wr_bin + ptr_t'(wr_en_o);
    assign wr_gray_next = (wr_bin_next >> 1) ^ wr_bin_next;
    assign rq_bin       = gray_to_bin(rq_ptr_i);
    assign cnt_next     = wr_bin_next - rq_bin;

    always_ff @(posedge wr_clk_i) begin
        if (wr_rst_i) begin
            wr_bin   <= '0;
            wr_gray  <= '0;
            status_q <= '0;
        end else begin
            wr_bin          <= wr_bin_next;
            wr_gray         <= wr_gray_next;
            // full when next pointer has wrapped once past the read pointer
            status_q.full   <= (wr_gray_next ==
                                {~rq_ptr_i[ADDR_WIDTH:ADDR_WIDTH-1],
                                 rq_ptr_i[ADDR_WIDTH-2:0]});
            status_q.a_full <= (cnt_next >= cnt_t'(FIFO_DEPTH - 1));
            status_q.wr_cnt <= wr_bin - rq_bin;  // one edge behind the pointer
        end
    end

    assign wr_addr_o   = wr_bin[ADDR_WIDTH-1:0];
    assign wr_ptr_o    = wr_gray;
    assign wr_status_o = status_q;

    // no advance once a full depth ahead of the read pointer
    a_no_adv_full: assert property (@(posedge wr_clk_i) disable iff (wr_rst_i)
        (wr_bin - rq_bin) == ptr_t'(FIFO_DEPTH) |=> $stable(wr_gray));

    a_cnt_range: assert property (@(posedge wr_clk_i) disable iff (wr_rst_i)
        status_q.wr_cnt <= cnt_t'(FIFO_DEPTH));

endmodule
